// ==== trace_capture.f ====
+incdir+.
trace_capture_pkg.sv
trace_ram.sv
capture_sequencer.sv
flush_timer.sv
capture_writer.sv
store_arbiter.sv
readout_control.sv
trace_capture_top.sv
trace_capture_props.sv
tb_trace_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the trace capture testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f trace_capture.f \
   --top-module tb_trace_capture -o tb_trace_capture || exit 1
result=$(./obj_dir/tb_trace_capture 2>&1)
echo "$result"
echo "$result" | grep -q "All checks passed" && echo "simulation passed" || {
   echo "simulation failed"
   exit 1
}

// ==== tb_trace_capture.sv ====
// testbench for the trace capture controller, runs a table of capture runs against a scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "trace_capture_params.svh"

module tb_trace_capture
   import trace_capture_pkg::*;
();

   localparam int POL_NOW  = 0;
   localparam int POL_SLOW = 1;
   localparam int POL_HOLD = 2;
   localparam int NUM_RUNS = 5;

   // words, max input gap, credit policy, run cycle credits resume, words before stop
   typedef struct packed {
      int n_words;
      int gap_max;
      int policy;
      int resume;
      int stop_at;
   } run_row_t;

   localparam run_row_t RUNS [NUM_RUNS] = '{
      '{12, 2, POL_NOW,  0,  12},
      '{40, 0, POL_NOW,  0,  40},
      '{30, 0, POL_HOLD, 60, 30},
      '{25, 3, POL_SLOW, 0,  20},
      '{12, 1, POL_NOW,  0,  8}
   };

   logic        clk;
   logic        arst_n;
   logic        start;
   logic        stop;
   logic        in_valid;
   trace_word_t in_data;
   logic        in_ready;
   logic        out_valid;
   trace_word_t out_data;
   logic        out_credit;
   logic        busy;

   trace_word_t expected_q [$];
   trace_word_t exp_word;
   int          cycle_cnt;
   int          run_start;
   int          run_policy;
   int          resume_at;
   int          accepted_run;
   int          out_run;
   int          sink_credits;
   logic        first_out_seen;
   logic        credit_next;

   trace_capture_top u_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .stop       (stop),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_credit (out_credit),
      .busy       (busy)
   );

   bind trace_capture_top trace_capture_props u_props (
      .clk        (clk),
      .arst_n     (arst_n),
      .out_valid  (out_valid),
      .out_credit (out_credit),
      .rd_gnt     (rd_gnt),
      .ram_we     (ram_we),
      .in_ready   (in_ready),
      .busy       (busy),
      .credits    (u_readout.credits)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // credit returns decided at the negedge, driven just after the rising edge
   always @(posedge clk) begin
      #1;
      out_credit = credit_next;
   end

   task automatic stop_on_error(input string what);
      $display("FAIL @%0t: %s", $time, what);
      $display("Checks failed");
      $fatal(1, "stopping at the first error");
   endtask

   function automatic int count_table_words();
      int total;
      int k;
      total = 0;
      for (k = 0; k < NUM_RUNS; k++) begin
         total = total + RUNS[k].n_words;
      end
      return total;
   endfunction

   // scoreboard, sink credit count and credit policy, all sampled mid cycle
   always @(negedge clk) begin
      if (arst_n) begin
         if (in_valid && in_ready) begin
            expected_q.push_back(in_data);
            accepted_run = accepted_run + 1;
         end
         if (out_valid) begin
            assert (expected_q.size() > 0)
               else stop_on_error("out_valid with no accepted word outstanding");
            exp_word = expected_q.pop_front();
            assert (out_data == exp_word)
               else stop_on_error($sformatf("out_data %h, expected %h", out_data, exp_word));
            assert (sink_credits > 0)
               else stop_on_error("out_valid while the sink has no credit");
            if (!first_out_seen) begin
               assert (cycle_cnt - run_start >= `TC_SETTLE_CYCLES + 3)
                  else stop_on_error("first word out too soon after start");
            end
            first_out_seen = 1'b1;
            sink_credits = sink_credits - 1;
            out_run = out_run + 1;
         end
         if (out_credit) begin
            sink_credits = sink_credits + 1;
         end
         // last cycle of withheld credits: buffer full and writer stalled
         if (run_policy == POL_HOLD && cycle_cnt - run_start == resume_at) begin
            assert (!in_ready)
               else stop_on_error("in_ready still high with credits withheld");
            assert (accepted_run <= `TC_FILL_LIMIT + `TC_INIT_CREDITS + 1)
               else stop_on_error($sformatf("%0d words accepted while stalled", accepted_run));
            assert (out_run <= `TC_INIT_CREDITS)
               else stop_on_error($sformatf("%0d words out with credits withheld", out_run));
         end
         credit_next = 1'b0;
         if (sink_credits < `TC_INIT_CREDITS) begin
            case (run_policy)
               POL_NOW:  credit_next = 1'b1;
               POL_SLOW: credit_next = (cycle_cnt % 5 == 0);
               default:  credit_next = (cycle_cnt - run_start >= resume_at);
            endcase
         end
      end
   end

   task automatic check_idle(input int n);
      repeat (n) begin
         @(negedge clk);
         assert (!in_ready && !out_valid && !busy)
            else stop_on_error("in_ready, out_valid or busy high while idle");
      end
      @(posedge clk);
      #1;
   endtask

   task automatic send_word(input trace_word_t word, input int gap);
      in_valid = 1'b0;
      repeat (gap) begin
         @(posedge clk);
         #1;
      end
      in_valid = 1'b1;
      in_data  = word;
      // ready seen at the negedge means the word transfers on the next edge
      @(negedge clk);
      while (!in_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic run_capture(input run_row_t row);
      int i;
      int n_sent;
      n_sent = (row.stop_at < row.n_words) ? row.stop_at : row.n_words;
      run_policy     = row.policy;
      resume_at      = row.resume;
      accepted_run   = 0;
      out_run        = 0;
      first_out_seen = 1'b0;
      run_start      = cycle_cnt;
      start          = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      for (i = 0; i < n_sent; i++) begin
         send_word($urandom(), $urandom_range(row.gap_max));
      end
      stop = 1'b1;
      @(posedge clk);
      #1;
      stop = 1'b0;
      // a word still offered after stop must be refused
      in_valid = (row.stop_at < row.n_words);
      in_data  = $urandom();
      while (busy) begin
         @(negedge clk);
         assert (!in_ready)
            else stop_on_error("in_ready high after stop");
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      assert (expected_q.size() == 0)
         else stop_on_error($sformatf("%0d accepted words never came out", expected_q.size()));
      assert (out_run == accepted_run)
         else stop_on_error($sformatf("%0d words out for %0d in", out_run, accepted_run));
   endtask

   initial begin
      int limit;
      limit = count_table_words() * 40 + 200;
      repeat (limit) begin
         @(posedge clk);
      end
      $display("timeout: the runs did not finish within %0d cycles", limit);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      int r;
      void'($urandom(32'ha02f_8228));
      arst_n         = 1'b0;
      start          = 1'b0;
      stop           = 1'b0;
      in_valid       = 1'b0;
      in_data        = '0;
      out_credit     = 1'b0;
      cycle_cnt      = 0;
      run_start      = 0;
      run_policy     = POL_NOW;
      resume_at      = 0;
      accepted_run   = 0;
      out_run        = 0;
      sink_credits   = `TC_INIT_CREDITS;
      first_out_seen = 1'b0;
      credit_next    = 1'b0;
      repeat (3) begin
         @(posedge clk);
      end
      #1;
      arst_n = 1'b1;
      check_idle(6);
      for (r = 0; r < NUM_RUNS; r++) begin
         run_capture(RUNS[r]);
         check_idle(4);
      end
      if (expected_q.size() == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("Checks failed");
         $fatal(1, "scoreboard not empty at the end");
      end
   end

endmodule

`default_nettype wire

// ==== trace_capture_props.sv ====
// bound checks on the output credit rule, buffer port sharing and input gating
`timescale 1ns/1ps
`default_nettype none

`include "trace_capture_params.svh"

module trace_capture_props
   import trace_capture_pkg::*;
(
   input logic    clk,
   input logic    arst_n,
   input logic    out_valid,
   input logic    out_credit,
   input logic    rd_gnt,
   input logic    ram_we,
   input logic    in_ready,
   input logic    busy,
   input credit_t credits
);

   // credits as the sink sees them, spent on out_valid and returned on out_credit
   credit_t sink_credits;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sink_credits <= credit_t'(`TC_INIT_CREDITS);
      end else if (out_valid && !out_credit) begin
         sink_credits <= sink_credits - 1'b1;
      end else if (!out_valid && out_credit) begin
         sink_credits <= sink_credits + 1'b1;
      end
   end

   a_valid_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid |-> sink_credits != '0)
      else $error("out_valid while the sink has no credit left");

   a_no_write_on_read: assert property (@(posedge clk) disable iff (!arst_n)
      !(ram_we && rd_gnt))
      else $error("ram write granted in the same cycle as a read");

   a_ready_needs_busy: assert property (@(posedge clk) disable iff (!arst_n)
      !busy |-> !in_ready)
      else $error("in_ready high while the controller is idle");

   a_credit_cap: assert property (@(posedge clk) disable iff (!arst_n)
      credits <= credit_t'(`TC_INIT_CREDITS))
      else $error("readout holds more credits than its initial pool");

endmodule

`default_nettype wire

// ==== trace_capture_top.sv ====
// streaming trace capture controller with internal ring buffer and credit output
`timescale 1ns/1ps
`default_nettype none

module trace_capture_top
   import trace_capture_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        start,
   input  logic        stop,
   input  logic        in_valid,
   input  trace_word_t in_data,
   output logic        in_ready,
   output logic        out_valid,
   output trace_word_t out_data,
   input  logic        out_credit,
   output logic        busy
);

   // sequencing
   logic        timer_load;
   fill_level_t timer_cycles;
   logic        timer_done;
   logic        wr_en;
   logic        rd_en;
   logic        wr_pipe_empty;
   logic        store_empty;

   // buffer access
   logic        wr_req;
   buf_addr_t   wr_addr;
   trace_word_t wr_data;
   logic        wr_gnt;
   logic        rd_req;
   buf_addr_t   rd_addr;
   logic        rd_gnt;
   logic        ram_we;
   buf_addr_t   ram_addr;
   trace_word_t ram_wdata;
   trace_word_t ram_rdata;

   capture_sequencer u_seq (
      .clk           (clk),
      .arst_n        (arst_n),
      .start         (start),
      .stop          (stop),
      .wr_pipe_empty (wr_pipe_empty),
      .store_empty   (store_empty),
      .timer_done    (timer_done),
      .timer_load    (timer_load),
      .timer_cycles  (timer_cycles),
      .wr_en         (wr_en),
      .rd_en         (rd_en),
      .busy          (busy),
      .state         ()
   );

   flush_timer u_timer (
      .clk    (clk),
      .arst_n (arst_n),
      .load   (timer_load),
      .cycles (timer_cycles),
      .done   (timer_done)
   );

   capture_writer u_writer (
      .clk        (clk),
      .arst_n     (arst_n),
      .en         (wr_en),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_ready   (in_ready),
      .wr_req     (wr_req),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_gnt     (wr_gnt),
      .pipe_empty (wr_pipe_empty)
   );

   store_arbiter u_arb (
      .clk         (clk),
      .arst_n      (arst_n),
      .wr_req      (wr_req),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .wr_gnt      (wr_gnt),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .rd_gnt      (rd_gnt),
      .ram_we      (ram_we),
      .ram_addr    (ram_addr),
      .ram_wdata   (ram_wdata),
      .store_empty (store_empty)
   );

   trace_ram u_ram (
      .clk   (clk),
      .we    (ram_we),
      .addr  (ram_addr),
      .wdata (ram_wdata),
      .rdata (ram_rdata)
   );

   readout_control u_readout (
      .clk         (clk),
      .arst_n      (arst_n),
      .en          (rd_en),
      .store_empty (store_empty),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .rd_gnt      (rd_gnt),
      .ram_rdata   (ram_rdata),
      .out_valid   (out_valid),
      .out_data    (out_data),
      .out_credit  (out_credit)
   );

endmodule

`default_nettype wire

// ==== readout_control.sv ====
// in-order buffer readout paced by output credits
`timescale 1ns/1ps
`default_nettype none

`include "trace_capture_params.svh"

module readout_control
   import trace_capture_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        en,
   input  logic        store_empty,
   output logic        rd_req,
   output buf_addr_t   rd_addr,
   input  logic        rd_gnt,
   input  trace_word_t ram_rdata,
   output logic        out_valid,
   output trace_word_t out_data,
   input  logic        out_credit
);

   buf_addr_t rd_ptr;
   credit_t   credits;
   logic      rd_pend;

   // a credit is reserved at the grant, so in-flight words are already paid for
   assign rd_req  = en & ~store_empty & (credits != '0);
   assign rd_addr = rd_ptr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr    <= '0;
         credits   <= credit_t'(`TC_INIT_CREDITS);
         rd_pend   <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         if (rd_gnt) begin
            rd_ptr <= (rd_ptr == buf_addr_t'(`TC_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end

         case ({rd_gnt, out_credit})
            2'b10: credits <= credits - 1'b1;
            2'b01: begin
               // pool is capped at its reset size
               if (credits != credit_t'(`TC_INIT_CREDITS)) begin
                  credits <= credits + 1'b1;
               end
            end
            default: credits <= credits;
         endcase

         // stage 1 tracks the ram access, stage 2 is the output
         rd_pend   <= rd_gnt;
         out_valid <= rd_pend;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_pend) begin
         out_data <= ram_rdata;
      end
   end

endmodule

`default_nettype wire

// ==== store_arbiter.sv ====
// single-port buffer arbiter with read priority and fill-level write block
`timescale 1ns/1ps
`default_nettype none

`include "trace_capture_params.svh"

module store_arbiter
   import trace_capture_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        wr_req,
   input  buf_addr_t   wr_addr,
   input  trace_word_t wr_data,
   output logic        wr_gnt,
   input  logic        rd_req,
   input  buf_addr_t   rd_addr,
   output logic        rd_gnt,
   output logic        ram_we,
   output buf_addr_t   ram_addr,
   output trace_word_t ram_wdata,
   output logic        store_empty
);

   fill_level_t fill;
   logic        almost_full;

   assign almost_full = (fill >= fill_level_t'(`TC_FILL_LIMIT));

   // reads always win, writes only with room left
   assign rd_gnt = rd_req;
   assign wr_gnt = wr_req & ~rd_req & ~almost_full;

   assign ram_we      = wr_gnt;
   assign ram_addr    = rd_gnt ? rd_addr : wr_addr;
   assign ram_wdata   = wr_data;
   assign store_empty = (fill == '0);

   // the grants are exclusive so one step per cycle at most
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fill <= '0;
      end else if (wr_gnt) begin
         fill <= fill + 1'b1;
      end else if (rd_gnt) begin
         fill <= fill - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== capture_writer.sv ====
// input holding register and write pointer feeding trace words to the buffer
`timescale 1ns/1ps
`default_nettype none

`include "trace_capture_params.svh"

module capture_writer
   import trace_capture_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        en,
   input  logic        in_valid,
   input  trace_word_t in_data,
   output logic        in_ready,
   output logic        wr_req,
   output buf_addr_t   wr_addr,
   output trace_word_t wr_data,
   input  logic        wr_gnt,
   output logic        pipe_empty
);

   logic      held;
   buf_addr_t wr_ptr;

   // accept when the holding slot is free or leaving this cycle
   assign in_ready   = en & (~held | wr_gnt);
   assign wr_req     = held;
   assign wr_addr    = wr_ptr;
   assign pipe_empty = ~held;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         held   <= 1'b0;
         wr_ptr <= '0;
      end else begin
         if (in_valid && in_ready) begin
            held <= 1'b1;
         end else if (wr_gnt) begin
            held <= 1'b0;
         end
         if (wr_gnt) begin
            wr_ptr <= (wr_ptr == buf_addr_t'(`TC_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         wr_data <= in_data;
      end
   end

endmodule

`default_nettype wire

// ==== flush_timer.sv ====
// loadable down-counter timing the settle and flush delays
`timescale 1ns/1ps
`default_nettype none

module flush_timer
   import trace_capture_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        load,
   input  fill_level_t cycles,
   output logic        done
);

   fill_level_t count;

   // counts down to zero and stays there until reloaded
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (load) begin
         count <= cycles;
      end else if (count != '0) begin
         count <= count - 1'b1;
      end
   end

   assign done = (count == '0);

endmodule

`default_nettype wire

// ==== capture_sequencer.sv ====
// run sequencer that enables the write and read sides and drains the buffer on stop
`timescale 1ns/1ps
`default_nettype none

`include "trace_capture_params.svh"

module capture_sequencer
   import trace_capture_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        start,
   input  logic        stop,
   input  logic        wr_pipe_empty,
   input  logic        store_empty,
   input  logic        timer_done,
   output logic        timer_load,
   output fill_level_t timer_cycles,
   output logic        wr_en,
   output logic        rd_en,
   output logic        busy,
   output seq_state_t  state
);

   // timer requests follow the state transitions
   always_comb begin
      timer_load   = 1'b0;
      timer_cycles = fill_level_t'(`TC_FLUSH_CYCLES);
      case (state)
         SEQ_IDLE: begin
            timer_load   = start;
            timer_cycles = fill_level_t'(`TC_SETTLE_CYCLES);
         end
         SEQ_STREAM:   timer_load = stop;
         SEQ_WR_FLUSH: timer_load = wr_pipe_empty & timer_done;
         // keep restarting until the store drains so the last reads leave the pipe
         SEQ_RD_FLUSH: timer_load = ~store_empty;
         default:      timer_load = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= SEQ_IDLE;
         wr_en <= 1'b0;
         rd_en <= 1'b0;
         busy  <= 1'b0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (start) begin
                  state <= SEQ_STREAM;
                  busy  <= 1'b1;
                  wr_en <= 1'b1;
               end
            end
            SEQ_STREAM: begin
               // settle delay over, start reading
               if (timer_done) begin
                  rd_en <= 1'b1;
               end
               if (stop) begin
                  state <= SEQ_WR_FLUSH;
                  wr_en <= 1'b0;
               end
            end
            SEQ_WR_FLUSH: begin
               rd_en <= 1'b1;
               if (wr_pipe_empty && timer_done) begin
                  state <= SEQ_RD_FLUSH;
               end
            end
            SEQ_RD_FLUSH: begin
               if (store_empty && timer_done) begin
                  state <= SEQ_IDLE;
                  rd_en <= 1'b0;
                  busy  <= 1'b0;
               end
            end
            default: state <= SEQ_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== trace_ram.sv ====
// single-port ring buffer storage with registered read data
`timescale 1ns/1ps
`default_nettype none

`include "trace_capture_params.svh"

module trace_ram (
   input  logic                      clk,
   input  logic                      we,
   input  logic [`TC_ADDR_WIDTH-1:0] addr,
   input  logic [`TC_DATA_WIDTH-1:0] wdata,
   output logic [`TC_DATA_WIDTH-1:0] rdata
);

   logic [`TC_DATA_WIDTH-1:0] mem [`TC_DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      // read data lands one cycle after the address
      rdata <= mem[addr];
   end

endmodule

`default_nettype wire

// ==== trace_capture_pkg.sv ====
// trace capture types shared by the sequencer, data path and testbench
`default_nettype none

`include "trace_capture_params.svh"

package trace_capture_pkg;

   typedef logic [`TC_DATA_WIDTH-1:0]   trace_word_t;
   typedef logic [`TC_ADDR_WIDTH-1:0]   buf_addr_t;

   // one bit wider than an address so a full buffer can be counted
   typedef logic [`TC_ADDR_WIDTH:0]     fill_level_t;

   typedef logic [`TC_CREDIT_WIDTH-1:0] credit_t;

   // run sequencing states
   typedef enum logic [1:0] {
      SEQ_IDLE     = 2'd0,
      SEQ_STREAM   = 2'd1,
      SEQ_WR_FLUSH = 2'd2,
      SEQ_RD_FLUSH = 2'd3
   } seq_state_t;

endpackage

`default_nettype wire

// ==== trace_capture_params.svh ====
// trace capture sizes, fill limit, credit pool and sequencer delays
`ifndef TRACE_CAPTURE_PARAMS_SVH
`define TRACE_CAPTURE_PARAMS_SVH

// trace word and ring buffer geometry
`define TC_DATA_WIDTH    32
`define TC_ADDR_WIDTH    4
`define TC_DEPTH         16

// writes stop two words short of a full buffer
`define TC_FILL_LIMIT    14

// output credit pool
`define TC_CREDIT_WIDTH  4
`define TC_INIT_CREDITS  4

// sequencer delays in clock cycles
`define TC_SETTLE_CYCLES 7
`define TC_FLUSH_CYCLES  7

`endif
